// File: sim.f
hw/icache_pkg.sv
hw/icache_ifs.sv
hw/icache_ctrl.sv
hw/icache_tag_array.sv
hw/icache_data_array.sv
hw/icache_refill.sv
hw/icache_top.sv
sim/icache_chk.sv
sim/icache_tb.sv

// File: sim/icache_tb.sv
`timescale 1ns/10ps
`default_nettype none

module icache_tb;

	localparam int set_bits = 6;
	localparam int num_sets = 1 << set_bits;
	localparam logic [63:0] mem_key = 64'h5a5a_c3c3_0f0f_9696;
	// worst miss with the widest gaps is under 60 cycles, about 300 accesses fit
	localparam int max_cycles = 20000;

	logic clk;
	logic rst_n;
	icache_pkg::addr_t cpu_req_addr;
	logic cpu_req_valid;
	logic flush;
	icache_pkg::word_t cpu_data_read;
	logic cpu_ready;
	icache_pkg::addr_t mem_req_addr;
	logic mem_req_valid;
	icache_pkg::word_t mem_data_read;
	logic mem_ready;

	logic last_beat; // fourth beat of the current burst
	logic exp_miss;
	logic saw_req;
	icache_pkg::word_t exp_data;
	logic [63:0] gap_rng = 64'd40;
	logic [63:0] addr_rng = 64'd40;
	logic [63:0] gap_mask;
	int unsigned cycle_count = 0;
	int unsigned fail_count = 0;
	int unsigned test_base = 0;
	int unsigned tests_passed = 0;
	int unsigned tests_failed = 0;

	// reference cache, tags hold the full line number
	logic m_valid [2][num_sets];
	logic [63:0] m_line [2][num_sets];
	logic m_lru [num_sets];

	icache_top i_icache_top (
		.clk (clk),
		.rst_n (rst_n),
		.cpu_req_addr (cpu_req_addr),
		.cpu_req_valid (cpu_req_valid),
		.flush (flush),
		.cpu_data_read (cpu_data_read),
		.cpu_ready (cpu_ready),
		.mem_req_addr (mem_req_addr),
		.mem_req_valid (mem_req_valid),
		.mem_data_read (mem_data_read),
		.mem_ready (mem_ready)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) cycle_count <= cycle_count + 1;
	always @(posedge clk) if (mem_req_valid) saw_req <= 1'b1;

	function automatic logic [63:0] xorshift64(input logic [63:0] x);
		logic [63:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 7);
		y = y ^ (y << 17);
		return y;
	endfunction

	function automatic int unsigned total_errors();
		return fail_count + i_icache_top.i_icache_chk.err_count;
	endfunction

	// response data and hit or miss against the reference
	data_ok: assert property (@(posedge clk) disable iff (!rst_n)
		cpu_ready |-> cpu_data_read == exp_data)
	else begin
		fail_count++;
		$display("Fail %0t cpu_data_read expected %h got %h", $time, exp_data,
			$sampled(cpu_data_read));
	end

	miss_ok: assert property (@(posedge clk) disable iff (!rst_n)
		cpu_ready |-> saw_req == exp_miss)
	else begin
		fail_count++;
		$display("Fail %0t mem_req_valid expected %0b got %0b", $time, exp_miss, saw_req);
	end

	hit_latency: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(cpu_req_valid) && !exp_miss |-> ##2 cpu_ready)
	else begin
		fail_count++;
		$display("Fail %0t cpu_ready expected 1 got 0", $time);
	end

	miss_latency: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(cpu_req_valid) && exp_miss |-> ##2 mem_req_valid)
	else begin
		fail_count++;
		$display("Fail %0t mem_req_valid expected 1 got 0", $time);
	end

	fill_latency: assert property (@(posedge clk) disable iff (!rst_n)
		mem_ready && last_beat |-> ##2 cpu_ready)
	else begin
		fail_count++;
		$display("Fail %0t cpu_ready expected 1 got 0", $time);
	end

	line_addr: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(mem_req_valid) |-> mem_req_addr == {cpu_req_addr[63:5], 5'b0})
	else begin
		fail_count++;
		$display("Fail %0t mem_req_addr expected %h got %h", $time,
			{cpu_req_addr[63:5], 5'b0}, $sampled(mem_req_addr));
	end

	// memory answers with address xor key, gaps from xorshift
	initial begin : memory_model
		logic [63:0] line;
		forever begin
			@(negedge clk);
			if (mem_req_valid) begin
				line = mem_req_addr;
				for (int b = 0; b < 4; b++) begin
					gap_rng = xorshift64(gap_rng);
					repeat (int'(gap_rng & gap_mask)) @(negedge clk);
					mem_ready = 1'b1;
					mem_data_read = (line + 64'(b * 8)) ^ mem_key;
					last_beat = (b == 3);
					@(negedge clk);
					mem_ready = 1'b0;
					last_beat = 1'b0;
				end
			end
		end
	end

	task automatic model_access(input icache_pkg::addr_t a, output logic miss);
		int unsigned idx;
		logic [63:0] line;
		int victim;
		idx = (a >> 5) & (num_sets - 1);
		line = a >> 5;
		miss = 1'b1;
		for (int w = 0; w < 2; w++) begin
			if (m_valid[w][idx] && m_line[w][idx] == line) begin
				miss = 1'b0;
				m_lru[idx] = (w == 0); // other way becomes lru
			end
		end
		if (miss) begin
			victim = !m_valid[0][idx] ? 0 : (!m_valid[1][idx] ? 1 : int'(m_lru[idx]));
			m_valid[victim][idx] = 1'b1;
			m_line[victim][idx] = line;
			m_lru[idx] = (victim == 0);
		end
	endtask

	task automatic fetch(input icache_pkg::addr_t a);
		logic miss;
		model_access(a, miss);
		@(negedge clk);
		cpu_req_addr = a;
		exp_data = {a[63:3], 3'b0} ^ mem_key;
		exp_miss = miss;
		saw_req = 1'b0;
		cpu_req_valid = 1'b1;
		do @(negedge clk); while (!cpu_ready);
		cpu_req_valid = 1'b0;
	endtask

	task automatic fetch_line(input icache_pkg::addr_t base);
		for (int i = 0; i < 4; i++) begin
			fetch(base + 64'(i * 8));
		end
	endtask

	task automatic flush_cache();
		@(negedge clk);
		flush = 1'b1;
		@(negedge clk);
		flush = 1'b0;
		for (int s = 0; s < num_sets; s++) begin
			m_valid[0][s] = 1'b0;
			m_valid[1][s] = 1'b0;
			m_lru[s] = 1'b0;
		end
	endtask

	task automatic report_test(input string name);
		int unsigned errs;
		@(negedge clk); // checks on the last response fire at the edge before this
		errs = total_errors() - test_base;
		if (errs == 0) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errs);
		end
		test_base = total_errors();
	endtask

	initial begin
		rst_n = 1'b0;
		cpu_req_addr = '0;
		cpu_req_valid = 1'b0;
		flush = 1'b0;
		mem_data_read = '0;
		mem_ready = 1'b0;
		last_beat = 1'b0;
		exp_miss = 1'b0;
		exp_data = '0;
		saw_req = 1'b0;
		gap_mask = 64'd0;
		for (int s = 0; s < num_sets; s++) begin
			m_valid[0][s] = 1'b0;
			m_valid[1][s] = 1'b0;
			m_lru[s] = 1'b0;
		end
		repeat (5) @(negedge clk);
		rst_n = 1'b1;

		fetch_line(64'h8000_0000);
		report_test("cold miss then hit");

		// same set 2, lines 0x800 apart
		fetch(64'h8000_0040);
		fetch(64'h8000_0840);
		fetch(64'h8000_0048);
		fetch(64'h8000_0850);
		report_test("two-way residency");

		fetch(64'h8000_0040); // way of 0x840 becomes lru
		fetch(64'h8000_1040);
		fetch(64'h8000_0058);
		fetch(64'h8000_0840);
		report_test("lru eviction");

		fetch(64'h8000_0048);
		flush_cache();
		fetch(64'h8000_0048);
		fetch(64'h8000_0058);
		report_test("flush");

		gap_mask = 64'd7;
		for (int i = 0; i < 4; i++) begin
			fetch_line(64'h8800_00a0 + 64'(i * 'h800));
		end
		report_test("memory back-pressure");

		gap_mask = 64'd3;
		for (int i = 0; i < 200; i++) begin
			addr_rng = xorshift64(addr_rng);
			fetch(64'h9000_0000 | (addr_rng & 64'h1878)); // four sets, four tags
		end
		report_test("random stream");

		repeat (4) @(negedge clk);
		$display("tests passed %0d, failed %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && total_errors() == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	initial begin
		wait (cycle_count >= max_cycles);
		$display("timeout: no result after %0d cycles, a fetch never completed", cycle_count);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/icache_chk.sv
`timescale 1ns/10ps
`default_nettype none

module icache_chk (
	input logic clk,
	input logic rst_n,
	input logic cpu_ready,
	input logic mem_req_valid,
	input icache_pkg::word_t cpu_data_read
);

	int unsigned err_count = 0; // failed assertions so far

	// ready is a one-cycle strobe
	ready_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		cpu_ready |=> !cpu_ready)
	else begin
		err_count++;
		$error("cpu_ready stayed high for a second cycle");
	end

	// a response never overlaps an open line request
	req_vs_ready: assert property (@(posedge clk) disable iff (!rst_n)
		!(mem_req_valid && cpu_ready))
	else begin
		err_count++;
		$error("mem_req_valid and cpu_ready high together");
	end

	data_known: assert property (@(posedge clk) disable iff (!rst_n)
		cpu_ready |-> !$isunknown(cpu_data_read))
	else begin
		err_count++;
		$error("cpu_data_read unknown during cpu_ready");
	end

endmodule

bind icache_top icache_chk i_icache_chk (
	.clk (clk),
	.rst_n (rst_n),
	.cpu_ready (cpu_ready),
	.mem_req_valid (mem_req_valid),
	.cpu_data_read (cpu_data_read)
);

`default_nettype wire

// File: hw/icache_top.sv
`timescale 1ns/10ps
`default_nettype none

module icache_top #(
	parameter int set_bits = 6
) (
	input logic clk,
	input logic rst_n,
	input icache_pkg::addr_t cpu_req_addr,
	input logic cpu_req_valid,
	input logic flush,
	output icache_pkg::word_t cpu_data_read,
	output logic cpu_ready,
	output icache_pkg::addr_t mem_req_addr,
	output logic mem_req_valid,
	input icache_pkg::word_t mem_data_read,
	input logic mem_ready
);

	logic refill_start;
	logic fill_done;
	icache_pkg::beat_t word_sel;
	logic [set_bits-1:0] req_index;

	// address split, word select sits just above the byte offset in a word
	assign word_sel = cpu_req_addr[icache_pkg::offset_bits-1 -: icache_pkg::beat_bits];
	assign req_index = cpu_req_addr[icache_pkg::offset_bits +: set_bits];

	icache_lookup_if #(.set_bits(set_bits)) lk_if ();
	icache_fill_if #(.set_bits(set_bits)) fl_if ();

	icache_ctrl #(.set_bits(set_bits)) i_icache_ctrl (
		.clk (clk),
		.rst_n (rst_n),
		.cpu_req_valid (cpu_req_valid),
		.flush (flush),
		.cpu_ready (cpu_ready),
		.lk (lk_if.ctrl),
		.refill_start (refill_start),
		.fill_done (fill_done),
		.req_index (req_index)
	);

	icache_tag_array #(.set_bits(set_bits)) i_icache_tag_array (
		.clk (clk),
		.rst_n (rst_n),
		.lk (lk_if.tags),
		.fl (fl_if.arrays),
		.req_addr (cpu_req_addr)
	);

	icache_data_array #(.set_bits(set_bits)) i_icache_data_array (
		.clk (clk),
		.lk (lk_if.data),
		.fl (fl_if.arrays),
		.word_sel (word_sel),
		.cpu_data_read (cpu_data_read)
	);

	icache_refill #(.set_bits(set_bits)) i_icache_refill (
		.clk (clk),
		.rst_n (rst_n),
		.refill_start (refill_start),
		.req_addr (cpu_req_addr),
		.victim_way (lk_if.victim_way),
		.fl (fl_if.refill),
		.fill_done (fill_done),
		.mem_req_addr (mem_req_addr),
		.mem_req_valid (mem_req_valid),
		.mem_data_read (mem_data_read),
		.mem_ready (mem_ready)
	);

endmodule

`default_nettype wire

// File: hw/icache_refill.sv
`timescale 1ns/10ps
`default_nettype none

module icache_refill #(
	parameter int set_bits = 6
) (
	input logic clk,
	input logic rst_n,
	input logic refill_start,
	input icache_pkg::addr_t req_addr,
	input icache_pkg::way_t victim_way,
	icache_fill_if.refill fl,
	output logic fill_done,
	output icache_pkg::addr_t mem_req_addr,
	output logic mem_req_valid,
	input icache_pkg::word_t mem_data_read,
	input logic mem_ready
);

	localparam int tag_bits = icache_pkg::addr_bits - set_bits - icache_pkg::offset_bits;

	logic active_q; // beats still expected
	logic req_valid_q;
	icache_pkg::beat_t beat_q;
	logic [tag_bits-1:0] tag_q;
	logic [set_bits-1:0] index_q;
	icache_pkg::way_t way_q;

	logic beat_we;
	logic last_beat;

	assign beat_we = active_q & mem_ready;
	assign last_beat = (beat_q == icache_pkg::beat_t'(icache_pkg::line_words - 1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active_q <= 1'b0;
			req_valid_q <= 1'b0;
			beat_q <= '0;
		end else if (refill_start) begin
			active_q <= 1'b1;
			req_valid_q <= 1'b1;
			beat_q <= '0;
		end else begin
			if (req_valid_q && mem_ready) begin
				req_valid_q <= 1'b0; // request taken with first beat
			end
			if (beat_we) begin
				beat_q <= beat_q + 1'b1;
				if (last_beat) begin
					active_q <= 1'b0;
				end
			end
		end
	end

	// line target captured once per miss
	always_ff @(posedge clk) begin
		if (refill_start) begin
			tag_q <= req_addr[icache_pkg::addr_bits-1 -: tag_bits];
			index_q <= req_addr[icache_pkg::offset_bits +: set_bits];
			way_q <= victim_way;
		end
	end

	assign mem_req_addr = {tag_q, index_q, {icache_pkg::offset_bits{1'b0}}}; // line aligned
	assign mem_req_valid = req_valid_q;

	assign fl.fill_we = beat_we;
	assign fl.fill_beat = beat_q;
	assign fl.fill_way = way_q;
	assign fl.fill_index = index_q;
	assign fl.fill_data = mem_data_read;
	assign fl.fill_last = last_beat;
	assign fl.fill_tag = tag_q;

	// same cycle as the fourth beat so ctrl re-looks up right after the write
	assign fill_done = beat_we & last_beat;

endmodule

`default_nettype wire

// File: hw/icache_data_array.sv
`timescale 1ns/10ps
`default_nettype none

module icache_data_array #(
	parameter int set_bits = 6
) (
	input logic clk,
	icache_lookup_if.data lk,
	icache_fill_if.arrays fl,
	input icache_pkg::beat_t word_sel,
	output icache_pkg::word_t cpu_data_read
);

	localparam int num_sets = 1 << set_bits;

	// one bank per way, line_words words per set
	icache_pkg::word_t mem_q [2][num_sets][icache_pkg::line_words];

	// refill beats land at their word slot
	always_ff @(posedge clk) begin
		if (fl.fill_we) begin
			mem_q[fl.fill_way][fl.fill_index][fl.fill_beat] <= fl.fill_data;
		end
	end

	// read word held through respond
	always_ff @(posedge clk) begin
		if (lk.lookup_en) begin
			cpu_data_read <= mem_q[lk.hit_way][lk.index][word_sel];
		end
	end

endmodule

`default_nettype wire

// File: hw/icache_tag_array.sv
`timescale 1ns/10ps
`default_nettype none

module icache_tag_array #(
	parameter int set_bits = 6
) (
	input logic clk,
	input logic rst_n,
	icache_lookup_if.tags lk,
	icache_fill_if.arrays fl,
	input icache_pkg::addr_t req_addr
);

	localparam int num_sets = 1 << set_bits;
	localparam int tag_bits = icache_pkg::addr_bits - set_bits - icache_pkg::offset_bits;

	logic [num_sets-1:0] valid_q [2];
	logic [num_sets-1:0] lru_q; // names the way to evict next
	logic [tag_bits-1:0] tag_q [2][num_sets];

	logic [tag_bits-1:0] req_tag;
	logic [1:0] way_hit;

	assign req_tag = req_addr[icache_pkg::addr_bits-1 -: tag_bits];

	// compare both ways at once
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			way_hit[w] = valid_q[w][lk.index] && (tag_q[w][lk.index] == req_tag);
		end
	end

	assign lk.hit = lk.lookup_en & (|way_hit);
	assign lk.hit_way = way_hit[1];

	// invalid ways go first, then lru
	always_comb begin
		if (!valid_q[0][lk.index]) begin
			lk.victim_way = 1'b0;
		end else if (!valid_q[1][lk.index]) begin
			lk.victim_way = 1'b1;
		end else begin
			lk.victim_way = lru_q[lk.index];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n || lk.flush_all) begin
			valid_q[0] <= '0;
			valid_q[1] <= '0;
			lru_q <= '0;
		end else begin
			if (lk.touch) begin
				lru_q[lk.index] <= ~lk.touch_way; // other way becomes lru
			end
			if (fl.fill_we && fl.fill_last) begin
				valid_q[fl.fill_way][fl.fill_index] <= 1'b1;
				lru_q[fl.fill_index] <= ~fl.fill_way;
			end
		end
	end

	// tag written with the last beat of the line
	always_ff @(posedge clk) begin
		if (fl.fill_we && fl.fill_last) begin
			tag_q[fl.fill_way][fl.fill_index] <= fl.fill_tag;
		end
	end

endmodule

`default_nettype wire

// File: hw/icache_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module icache_ctrl #(
	parameter int set_bits = 6
) (
	input logic clk,
	input logic rst_n,
	input logic cpu_req_valid,
	input logic flush,
	output logic cpu_ready,
	icache_lookup_if.ctrl lk,
	output logic refill_start,
	input logic fill_done,
	input logic [set_bits-1:0] req_index
);

	typedef enum logic [1:0] {
		st_idle,
		st_lookup,
		st_refill,
		st_respond
	} state_t;

	state_t state_q;
	state_t state_d;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= st_idle;
		end else begin
			state_q <= state_d;
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			st_idle: begin
				// flush wins over a request in the same cycle
				if (!flush && cpu_req_valid) begin
					state_d = st_lookup;
				end
			end
			st_lookup: begin
				if (lk.hit) begin
					state_d = st_respond;
				end else begin
					state_d = st_refill;
				end
			end
			st_refill: begin
				if (fill_done) begin
					state_d = st_lookup; // look up again, now a hit
				end
			end
			st_respond: begin
				state_d = st_idle;
			end
			default: begin
				state_d = st_idle;
			end
		endcase
	end

	assign lk.index = req_index;
	assign lk.lookup_en = (state_q == st_lookup);

	// hit refreshes lru for the hitting way
	assign lk.touch = lk.lookup_en & lk.hit;
	assign lk.touch_way = lk.hit_way;

	assign lk.flush_all = (state_q == st_idle) & flush;

	assign refill_start = lk.lookup_en & ~lk.hit; // one-cycle pulse
	assign cpu_ready = (state_q == st_respond);

endmodule

`default_nettype wire

// File: hw/icache_ifs.sv
`timescale 1ns/10ps
`default_nettype none

// lookup path: ctrl asks, tags answer, data reads the hitting way
interface icache_lookup_if #(
	parameter int set_bits = 6
);
	logic lookup_en;
	logic touch; // lru update on hit
	icache_pkg::way_t touch_way;
	logic flush_all;
	logic [set_bits-1:0] index;
	logic hit;
	icache_pkg::way_t hit_way;
	icache_pkg::way_t victim_way;

	modport ctrl (output lookup_en, touch, touch_way, flush_all, index, input hit, hit_way);
	modport tags (input lookup_en, touch, touch_way, flush_all, index,
		output hit, hit_way, victim_way);
	modport data (input index, lookup_en, hit_way);
endinterface

// refill beats into tag and data arrays
interface icache_fill_if #(
	parameter int set_bits = 6
);
	localparam int tag_bits = icache_pkg::addr_bits - set_bits - icache_pkg::offset_bits;

	logic fill_we;
	icache_pkg::beat_t fill_beat;
	icache_pkg::way_t fill_way;
	logic [set_bits-1:0] fill_index;
	icache_pkg::word_t fill_data;
	logic fill_last; // fourth beat, tag write goes with it
	logic [tag_bits-1:0] fill_tag;

	modport refill (output fill_we, fill_beat, fill_way, fill_index, fill_data, fill_last,
		fill_tag);
	modport arrays (input fill_we, fill_beat, fill_way, fill_index, fill_data, fill_last,
		fill_tag);
endinterface

`default_nettype wire

// File: hw/icache_pkg.sv
`default_nettype none

package icache_pkg;

	// fetch address and data widths
	localparam int addr_bits = 64;
	localparam int word_bits = 64;

	// line geometry, 32-byte lines of four 64-bit words
	localparam int offset_bits = 5;
	localparam int line_words = 4;
	localparam int beat_bits = 2; // word select within a line

	// byte address
	typedef logic [addr_bits-1:0] addr_t;

	// fetch word, also one memory beat
	typedef logic [word_bits-1:0] word_t;

	// word within a line
	typedef logic [beat_bits-1:0] beat_t;

	// way 0 or way 1
	typedef logic [0:0] way_t;

endpackage

`default_nettype wire
